// ==== verilog/lcd_regs_pkg.sv ====
package lcd_regs_pkg;

	// ======================================================================
	// AHB bus encodings
	// ======================================================================

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// only OKAY is ever driven by this slave
	typedef enum logic [1:0] {
		OKAY  = 2'b00,
		ERROR = 2'b01,
		RETRY = 2'b10,
		SPLIT = 2'b11
	} hresp_t;

	// front end states, CTRL_ST waits for a transfer
	typedef enum logic [1:0] {
		CTRL_ST  = 2'b00,
		WR_OP_ST = 2'b01,
		RD_OP_ST = 2'b10
	} slave_state_t;

	// ======================================================================
	// widths and basic types
	// ======================================================================

	localparam int DATA_W     = 32;
	localparam int OFFS_W     = 24;
	localparam int WORD_IDX_W = 3;

	typedef logic [DATA_W-1:0] word_t;

	// byte address with the top byte of HADDR dropped
	typedef logic [OFFS_W-1:0] offset_t;

	// one data-phase request, sent to every bank at once
	typedef struct packed {
		logic    wr;
		logic    rd;
		offset_t offset;
		word_t   wdata;
	} bus_req_t;

	// full contents of one bank, word 0 at the bank base
	typedef word_t [(1 << WORD_IDX_W)-1:0] bank_regs_t;

	// ======================================================================
	// bank map
	// ======================================================================

	localparam int MAX_BANKS = 4;

	// 0 is the LCD timing bank, 1 the cursor bank
	// entries 2 and 3 are spare slots above the cursor bank
	localparam offset_t BANK_BASE [MAX_BANKS] = '{
		24'hE10000,
		24'hE10C00,
		24'hE11000,
		24'hE11400
	};

endpackage

// ==== verilog/ahb_slave_fsm.sv ====
module ahb_slave_fsm
	import lcd_regs_pkg::*;
#(
	parameter int NUM_BANKS = 2
) (
	input  logic                    HCLK,
	input  logic                    HRESET,
	input  logic                    HSEL,
	input  word_t                   HADDR,
	input  logic                    HWRITE,
	input  htrans_t                 HTRANS,
	input  word_t                   HWDATA,
	output word_t                   HRDATA,
	output logic                    HREADY,
	output hresp_t                  HRESP,
	output bus_req_t                req,
	input  logic [NUM_BANKS-1:0]    bank_hit,
	input  word_t [NUM_BANKS-1:0]   bank_rdata
);

	slave_state_t state_q;
	slave_state_t state_d;
	offset_t      offset_q;
	logic         accept;

	// ======================================================================
	// address phase
	// ======================================================================

	// single NONSEQ transfers only, burst and size are ignored
	assign accept = HSEL && (HTRANS == NONSEQ);

	// the decision is the same from every state, a new address phase
	// can overlap the data phase of the previous transfer
	always_comb begin
		if (accept) begin
			state_d = HWRITE ? WR_OP_ST : RD_OP_ST;
		end else begin
			state_d = CTRL_ST;
		end
	end

	always_ff @(posedge HCLK or posedge HRESET) begin
		if (HRESET) begin
			state_q <= CTRL_ST;
		end else begin
			state_q <= state_d;
		end
	end

	// low 24 bits only
	always_ff @(posedge HCLK) begin
		if (accept) begin
			offset_q <= HADDR[OFFS_W-1:0];
		end
	end

	// ======================================================================
	// data phase
	// ======================================================================

	// request to the banks, write data straight off the bus
	always_comb begin
		req.wr     = (state_q == WR_OP_ST);
		req.rd     = (state_q == RD_OP_ST);
		req.offset = offset_q;
		req.wdata  = HWDATA;
	end

	// read word of the hitting bank, zero on a miss
	always_comb begin
		HRDATA = '0;
		if (state_q == RD_OP_ST) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (bank_hit[i]) begin
					HRDATA = HRDATA | bank_rdata[i];
				end
			end
		end
	end

	// no wait states, in CTRL_ST ready only while accepting
	assign HREADY = (state_q != CTRL_ST) || accept;
	assign HRESP  = OKAY;

	// ======================================================================
	// checks
	// ======================================================================

	// bank windows must not overlap
	a_one_bank_hit: assert property (
		@(posedge HCLK) disable iff (HRESET)
		$onehot0(bank_hit)
	);

	a_resp_okay: assert property (
		@(posedge HCLK) disable iff (HRESET)
		HRESP == OKAY
	);

endmodule

// ==== verilog/reg_bank.sv ====
module reg_bank
	import lcd_regs_pkg::*;
#(
	parameter int BANK_IDX = 0
) (
	input  logic       HCLK,
	input  logic       HRESET,
	input  bus_req_t   req,
	output logic       hit,
	output word_t      rdata,
	output bank_regs_t regs
);

	// byte lane bits sit below the word index
	localparam int BYTE_W = $clog2(DATA_W / 8);
	localparam int LO     = BYTE_W + WORD_IDX_W;

	localparam offset_t BASE = BANK_BASE[BANK_IDX];

	logic                  base_match;
	logic [WORD_IDX_W-1:0] word_idx;

	// ======================================================================
	// address match
	// ======================================================================

	assign base_match = (req.offset[OFFS_W-1:LO] == BASE[OFFS_W-1:LO]);
	assign word_idx   = req.offset[LO-1:BYTE_W];

	// only meaningful during a data phase
	assign hit = base_match && (req.wr || req.rd);

	// ======================================================================
	// storage
	// ======================================================================

	// commits at the closing edge of the write data phase
	always_ff @(posedge HCLK or posedge HRESET) begin
		if (HRESET) begin
			regs <= '0;
		end else if (req.wr && hit) begin
			regs[word_idx] <= req.wdata;
		end
	end

	// read word, zero unless this bank is being read
	always_comb begin
		if (req.rd && hit) begin
			rdata = regs[word_idx];
		end else begin
			rdata = '0;
		end
	end

	// ======================================================================
	// checks
	// ======================================================================

	// display side sees no change without a write to this bank
	a_hold_without_write: assert property (
		@(posedge HCLK) disable iff (HRESET)
		!(req.wr && hit) |=> $stable(regs)
	);

endmodule

// ==== verilog/lcd_ahb_regs.sv ====
module lcd_ahb_regs
	import lcd_regs_pkg::*;
#(
	parameter int NUM_BANKS = 2
) (
	HCLK,
	HRESET,
	HSEL,
	HADDR,
	HWRITE,
	HTRANS,
	HWDATA,
	HRDATA,
	HREADY,
	HRESP,
	regs
);

	// register contents of every bank, as seen by the display side
	typedef bank_regs_t regfile_t [NUM_BANKS];

	input  logic     HCLK;
	input  logic     HRESET;
	input  logic     HSEL;
	input  word_t    HADDR;
	input  logic     HWRITE;
	input  htrans_t  HTRANS;
	input  word_t    HWDATA;
	output word_t    HRDATA;
	output logic     HREADY;
	output hresp_t   HRESP;
	output regfile_t regs;

	bus_req_t               req;
	logic [NUM_BANKS-1:0]   bank_hit;
	word_t [NUM_BANKS-1:0]  bank_rdata;

	// ======================================================================
	// bus front end
	// ======================================================================

	ahb_slave_fsm #(
		.NUM_BANKS (NUM_BANKS)
	) ahb_slave_fsm_i (
		.HCLK       (HCLK),
		.HRESET     (HRESET),
		.HSEL       (HSEL),
		.HADDR      (HADDR),
		.HWRITE     (HWRITE),
		.HTRANS     (HTRANS),
		.HWDATA     (HWDATA),
		.HRDATA     (HRDATA),
		.HREADY     (HREADY),
		.HRESP      (HRESP),
		.req        (req),
		.bank_hit   (bank_hit),
		.bank_rdata (bank_rdata)
	);

	// ======================================================================
	// register banks, all share one request
	// ======================================================================

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		reg_bank #(
			.BANK_IDX (i)
		) reg_bank_i (
			.HCLK   (HCLK),
			.HRESET (HRESET),
			.req    (req),
			.hit    (bank_hit[i]),
			.rdata  (bank_rdata[i]),
			.regs   (regs[i])
		);
	end

endmodule

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// running totals for the final report
int unsigned check_count = 0;
int unsigned error_count = 0;

// ======================================================================
// compare tasks
// ======================================================================

task automatic check_word(input string name, input word_t got, input word_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAILED at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAILED at %0t ns: %s got %0b expected %0b", $time, name, got, exp);
	end
endtask

task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAILED at %0t ns: %s got %s expected %s",
			$time, name, got.name(), exp.name());
	end
endtask

// one check per bank, each differing word printed
task automatic check_bank(input string name, input bank_regs_t got, input bank_regs_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		for (int i = 0; i < $size(got); i++) begin
			if (got[i] !== exp[i]) begin
				$display("FAILED at %0t ns: %s[%0d] got %08h expected %08h",
					$time, name, i, got[i], exp[i]);
			end
		end
	end
endtask

`endif

// ==== tests/tb_lcd_ahb_regs.sv ====
module tb_lcd_ahb_regs
	import lcd_regs_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_BANKS = 2;
	localparam int MAX_VEC   = 256;
	localparam int FIELDS    = 5;

	// columns of one vector line
	localparam int F_TEST  = 0;
	localparam int F_KIND  = 1;
	localparam int F_ADDR  = 2;
	localparam int F_TRANS = 3;
	localparam int F_DATA  = 4;

	// vector kinds
	localparam logic [31:0] K_WRITE = 32'd0;
	localparam logic [31:0] K_READ  = 32'd1;
	localparam logic [31:0] K_UNSEL = 32'd3;

	// register map, 8 words per bank
	localparam logic [23:0] LCD_BASE = 24'hE10000;
	localparam logic [23:0] CUR_BASE = 24'hE10C00;

	logic       HCLK;
	logic       HRESET;
	logic       HSEL;
	word_t      HADDR;
	logic       HWRITE;
	htrans_t    HTRANS;
	word_t      HWDATA;
	word_t      HRDATA;
	logic       HREADY;
	hresp_t     HRESP;
	bank_regs_t dut_regs [NUM_BANKS];

	logic [31:0] vec_mem [MAX_VEC*FIELDS];
	bank_regs_t  model_regs [NUM_BANKS];
	int          num_vec        = 0;
	int          cycle_count    = 0;
	int          cycle_limit    = 100000;
	int          tests_done     = 0;
	int          test_err_start = 0;
	logic [31:0] noise          = 32'h9553;

`include "tb_checks.svh"

	lcd_ahb_regs #(
		.NUM_BANKS (NUM_BANKS)
	) lcd_ahb_regs_i (
		.HCLK   (HCLK),
		.HRESET (HRESET),
		.HSEL   (HSEL),
		.HADDR  (HADDR),
		.HWRITE (HWRITE),
		.HTRANS (HTRANS),
		.HWDATA (HWDATA),
		.HRDATA (HRDATA),
		.HREADY (HREADY),
		.HRESP  (HRESP),
		.regs   (dut_regs)
	);

	// ======================================================================
	// helpers
	// ======================================================================

	function automatic logic [31:0] field(input int n, input int f);
		return vec_mem[n*FIELDS + f];
	endfunction

	function automatic logic [31:0] next_noise_word(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// bank and word of a bus address, top byte ignored
	function automatic logic find_word(input word_t addr, output int bank, output int word);
		logic [23:0] offs;
		offs = addr[23:0];
		bank = 0;
		word = int'(offs[4:2]);
		find_word = 1'b0;
		if (offs[23:5] == LCD_BASE[23:5]) begin
			find_word = 1'b1;
		end else if (offs[23:5] == CUR_BASE[23:5]) begin
			bank = 1;
			find_word = 1'b1;
		end
	endfunction

	// one falling edge, data phase of vector n-1, address phase of vector n
	task automatic run_cycle(input int n);
		logic [31:0] kind;
		logic [31:0] prev_kind;
		logic        prev_acc;
		word_t       exp_rdata;
		int          bank;
		int          word;
		for (int b = 0; b < NUM_BANKS; b++) begin
			check_bank($sformatf("regs[%0d]", b), dut_regs[b], model_regs[b]);
		end
		check_resp("HRESP", HRESP, OKAY);
		if (n >= 2 && (n - 1 == num_vec || field(n - 1, F_TEST) != field(n - 2, F_TEST))) begin
			if (error_count == test_err_start) begin
				$display("test %0d passed", field(n - 2, F_TEST));
			end else begin
				$display("test %0d: %0d errors", field(n - 2, F_TEST),
					error_count - test_err_start);
			end
			tests_done++;
			test_err_start = error_count;
		end
		prev_kind = K_READ;
		prev_acc  = 1'b0;
		if (n >= 1 && n - 1 < num_vec) begin
			prev_kind = field(n - 1, F_KIND);
			prev_acc  = (prev_kind != K_UNSEL) && (field(n - 1, F_TRANS) == 32'd2);
			exp_rdata = (prev_acc && prev_kind == K_READ) ? field(n - 1, F_DATA) : '0;
			check_word("HRDATA", HRDATA, exp_rdata);
			// commits at the next rising edge
			if (prev_acc && prev_kind != K_READ) begin
				if (find_word(field(n - 1, F_ADDR), bank, word)) begin
					model_regs[bank][word] = field(n - 1, F_DATA);
				end
			end
		end else begin
			check_word("HRDATA", HRDATA, '0);
		end
		// high only for the data phase of an accepted transfer
		check_bit("HREADY", HREADY, prev_acc);
		noise = next_noise_word(noise);
		HWDATA = (prev_kind != K_READ) ? field(n - 1, F_DATA) : noise;
		if (n < num_vec) begin
			kind   = field(n, F_KIND);
			HSEL   = (kind != K_UNSEL);
			HWRITE = (kind != K_READ);
			HADDR  = field(n, F_ADDR);
			HTRANS = htrans_t'(field(n, F_TRANS) & 32'h3);
		end else begin
			HSEL   = 1'b0;
			HWRITE = 1'b0;
			HTRANS = IDLE;
		end
	endtask

	// ======================================================================
	// clock, timeout and main sequence
	// ======================================================================

	initial begin
		HCLK = 1'b0;
		forever #2 HCLK = ~HCLK;
	end

	always @(posedge HCLK) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		HRESET = 1'b1;
		HSEL   = 1'b0;
		HADDR  = '0;
		HWRITE = 1'b0;
		HTRANS = IDLE;
		HWDATA = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			model_regs[b] = '0;
		end
		for (int i = 0; i < MAX_VEC*FIELDS; i++) begin
			vec_mem[i] = '1;
		end
		$readmemh("tests/lcd_ahb_vectors.txt", vec_mem);
		while (num_vec < MAX_VEC && vec_mem[num_vec*FIELDS] !== 32'hFFFF_FFFF) begin
			num_vec++;
		end
		cycle_limit = 4 * num_vec + 20;
		if (num_vec == 0) begin
			$display("no vectors could be read from tests/lcd_ahb_vectors.txt");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			repeat (3) @(posedge HCLK);
			@(negedge HCLK);
			HRESET = 1'b0;
			for (int n = 0; n <= num_vec + 1; n++) begin
				run_cycle(n);
				@(negedge HCLK);
			end
			$display("tests %0d, vectors %0d, checks %0d, errors %0d",
				tests_done, num_vec, check_count, error_count);
			if (error_count == 0) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== tests/lcd_ahb_vectors.txt ====
// test  kind(0 wr, 1 rd, 2 non-NONSEQ wr, 3 unselected wr)  haddr  htrans  data
// data is the write data or the expected read data, all columns hex
1 1 00E10000 2 00000000
1 1 00E10004 2 00000000
1 1 00E10008 2 00000000
1 1 00E1000C 2 00000000
1 1 00E10010 2 00000000
1 1 00E10014 2 00000000
1 1 00E10018 2 00000000
1 1 00E1001C 2 00000000
1 1 00E10C00 2 00000000
1 1 00E10C04 2 00000000
1 1 00E10C08 2 00000000
1 1 00E10C0C 2 00000000
1 1 00E10C10 2 00000000
1 1 00E10C14 2 00000000
1 1 00E10C18 2 00000000
1 1 00E10C1C 2 00000000
2 0 00E10000 2 3C1F0A27
2 1 00E10000 2 3C1F0A27
2 0 00E10004 2 0E02091F
2 1 00E10004 2 0E02091F
2 0 00E10008 2 07DF380E
2 1 00E10008 2 07DF380E
2 0 00E1000C 2 00000001
2 1 00E1000C 2 00000001
2 0 00E10010 2 80000000
2 1 00E10010 2 80000000
2 0 00E10014 2 80040000
2 1 00E10014 2 80040000
2 0 00E10018 2 0000092D
2 1 00E10018 2 0000092D
2 0 00E1001C 2 0000001E
2 1 00E1001C 2 0000001E
2 0 00E10C00 2 00000001
2 1 00E10C00 2 00000001
2 0 00E10C04 2 00000003
2 1 00E10C04 2 00000003
2 0 00E10C08 2 00FF00FF
2 1 00E10C08 2 00FF00FF
2 0 00E10C0C 2 00F0F0F0
2 1 00E10C0C 2 00F0F0F0
2 0 00E10C10 2 01400100
2 1 00E10C10 2 01400100
2 0 00E10C14 2 00003F3F
2 1 00E10C14 2 00003F3F
2 0 00E10C18 2 00000005
2 1 00E10C18 2 00000005
2 0 00E10C1C 2 00000007
2 1 00E10C1C 2 00000007
3 0 00E10008 2 DEADBEEF
3 1 00E10008 2 DEADBEEF
3 1 00E10C08 2 00FF00FF
3 0 00E10C10 2 CAFE1234
3 1 00E10C10 2 CAFE1234
3 1 00E10010 2 80000000
4 3 00E10000 2 11111111
4 2 00E10004 0 22222222
4 2 00E10008 1 33333333
4 2 00E1000C 3 44444444
4 1 00E10000 2 3C1F0A27
4 1 00E10004 2 0E02091F
4 1 00E10008 2 DEADBEEF
4 1 00E1000C 2 00000001
5 0 FFE10014 2 12345678
5 1 00E10014 2 12345678
5 1 AAE10014 2 12345678
5 0 00E10020 2 55AA55AA
5 1 00E10020 2 00000000
5 0 00E10800 2 0F0F0F0F
5 1 00E10800 2 00000000
5 1 00E10C20 2 00000000
5 1 00E10000 2 3C1F0A27

// ==== vlog.f ====
+incdir+include
verilog/lcd_regs_pkg.sv
verilog/ahb_slave_fsm.sv
verilog/reg_bank.sv
verilog/lcd_ahb_regs.sv
tests/tb_lcd_ahb_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module tb_lcd_ahb_regs \
	-o sim_tb_lcd_ahb_regs

output=$(./obj_dir/sim_tb_lcd_ahb_regs)
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi
